// ==== Makefile ====
.PHONY: all lint sim clean

all: sim

lint:
	verilator --lint-only --timing --assert -f itlb_top.f --top-module itlb_top

sim:
	verilator --binary --timing --assert -j 0 -f itlb_top.f --top-module tb_itlb -o sim_itlb
	./obj_dir/sim_itlb | tee sim.log
	grep -q "Test passed" sim.log

clean:
	rm -rf obj_dir sim.log

// ==== itlb_top.f ====
verilog/itlb_pkg.sv
verilog/itlb_array.sv
verilog/itlb_refill.sv
verilog/itlb_ctrl.sv
verilog/itlb_top.sv
testbench/tb_clock.sv
testbench/tb_itlb.sv

// ==== testbench/tb_clock.sv ====
`timescale 1ns/1ps

module tb_clock (
    output logic clk,
    output logic rst
);
    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;  // 4 ns period.
    end

    initial begin
        rst = 1'b0;
        repeat (10) @(posedge clk);
        #1 rst = 1'b1;
    end
endmodule

// ==== testbench/tb_itlb.sv ====
`timescale 1ns/1ps

module tb_itlb;
    localparam int ENTRIES = 8;
    localparam int NUM_RANDOM = 300;
    localparam int NUM_TXN = NUM_RANDOM + 8;
    localparam int TIMEOUT = 200 * NUM_TXN;

    typedef struct packed {
        logic           fault;
        logic           mega;
        logic           x;
        itlb_pkg::ppn_t ppn;
    } pte_t;

    logic                   clk;
    logic                   rst;
    logic [1:0]             req;
    itlb_pkg::vaddr_t [1:0] vaddr;
    logic                   flush;
    logic                   ready;
    itlb_pkg::paddr_t [1:0] paddr;
    logic [1:0]             exception;
    logic                   miss;
    itlb_pkg::l2_req_t      l2_req;
    logic                   l2_ready;
    itlb_pkg::l2_resp_t     l2_resp;

    logic [31:0]         drv_seed;
    logic [31:0]         rsp_seed;
    int                  cyc;
    int                  checks;
    int                  errors;
    int                  tag_count;
    itlb_pkg::walk_idx_t last_idx;

    // Requests waiting for the acceptance cycle, then answers waiting to go out.
    int                  chk_at_q[$];
    itlb_pkg::walk_idx_t chk_idx_q[$];
    itlb_pkg::vaddr_t    chk_va_q[$];
    int                  rsp_due_q[$];
    itlb_pkg::walk_idx_t rsp_idx_q[$];
    itlb_pkg::vaddr_t    rsp_va_q[$];

    tb_clock i_clock (.clk(clk), .rst(rst));

    itlb_top #(.ENTRIES(ENTRIES)) i_dut (
        .clk       (clk),
        .rst       (rst),
        .req       (req),
        .vaddr     (vaddr),
        .flush     (flush),
        .ready     (ready),
        .paddr     (paddr),
        .exception (exception),
        .miss      (miss),
        .l2_req    (l2_req),
        .l2_ready  (l2_ready),
        .l2_resp   (l2_resp)
    );

    function automatic logic [31:0] lcg_step(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic logic [31:0] next_rand();
        drv_seed = lcg_step(drv_seed);
        return drv_seed;
    endfunction

    function automatic logic [31:0] hash_vpn(input logic [31:0] v);
        logic [31:0] h;
        h = v * 32'h9e37_79b1;
        return h ^ (h >> 15);
    endfunction

    // Leaf entry per page. Every fourth vpn1 is a megapage.
    function automatic pte_t page_model(input itlb_pkg::vpn_t vpn);
        logic [31:0] h;
        pte_t        pte;
        pte.mega  = vpn.vpn1[1:0] == 2'b00;
        h         = pte.mega ? hash_vpn({22'd0, vpn.vpn1}) : hash_vpn({12'd1, vpn});
        pte.fault = h[3:0] == 4'h0;
        pte.x     = h[6:4] != 3'h0;
        pte.ppn   = {h[31:20], h[17:8]};
        return pte;
    endfunction

    function automatic itlb_pkg::paddr_t expected_paddr(input itlb_pkg::vaddr_t va);
        pte_t pte;
        pte = page_model(va[31:12]);
        return {pte.ppn.ppn1, pte.mega ? va[21:12] : pte.ppn.ppn0, va[11:0]};
    endfunction

    function automatic logic expected_exception(input itlb_pkg::vaddr_t va);
        pte_t pte;
        pte = page_model(va[31:12]);
        return pte.fault | ~pte.x;
    endfunction

    // 24 pages in a small window so the TLB has to evict.
    function automatic itlb_pkg::vaddr_t random_vaddr();
        logic [31:0] r;
        logic [31:0] s;
        r = next_rand();
        s = next_rand();
        return {10'h100 + 10'(r[31:16] % 6), 10'(r[15:8] % 4), s[31:20]};
    endfunction

    always @(posedge clk) begin
        cyc = cyc + 1;
        if (cyc >= TIMEOUT) begin
            $display("Timeout after %0d cycles, a translation never completed", cyc);
            $display("Test failed");
            $finish;
        end
    end

    // L2 responder.
    initial begin : responder
        logic send;
        pte_t pte;
        rsp_seed = ~32'h12d3_41c4;
        @(posedge rst);
        forever begin
            @(negedge clk);
            if (l2_req.req) begin
                if (l2_req.idx != last_idx) begin
                    tag_count++;
                end
                last_idx = l2_req.idx;
                chk_at_q.push_back(cyc + 2);  // Acceptance cycle.
                chk_idx_q.push_back(l2_req.idx);
                chk_va_q.push_back(l2_req.vaddr);
            end
            if (chk_at_q.size() > 0 && chk_at_q[0] == cyc) begin
                if (l2_ready) begin
                    rsp_seed = lcg_step(rsp_seed);
                    rsp_due_q.push_back(cyc + 1 + int'(rsp_seed[31:16] % 6));
                    rsp_idx_q.push_back(chk_idx_q[0]);
                    rsp_va_q.push_back(chk_va_q[0]);
                end
                void'(chk_at_q.pop_front());
                void'(chk_idx_q.pop_front());
                void'(chk_va_q.pop_front());
            end
            send = rsp_due_q.size() > 0 && rsp_due_q[0] <= cyc + 1;
            @(posedge clk);
            #1;
            rsp_seed = lcg_step(rsp_seed);
            l2_ready = rsp_seed[31:30] != 2'b00;
            l2_resp = '0;
            if (send) begin
                pte = page_model(rsp_va_q[0][31:12]);
                rsp_seed = lcg_step(rsp_seed);
                l2_resp.valid = 1'b1;
                l2_resp.idx   = rsp_idx_q[0];
                l2_resp.error = rsp_seed[31:29] == 3'b000;  // About one in eight.
                l2_resp.fault = pte.fault;
                l2_resp.mega  = pte.mega;
                l2_resp.x     = pte.x;
                l2_resp.ppn   = pte.ppn;
                void'(rsp_due_q.pop_front());
                void'(rsp_idx_q.pop_front());
                void'(rsp_va_q.pop_front());
            end
        end
    end

    task automatic check_port(input int p);
        itlb_pkg::paddr_t ep;
        logic             ee;
        ep = expected_paddr(vaddr[p]);
        ee = expected_exception(vaddr[p]);
        checks++;
        if (paddr[p] !== ep) begin
            errors++;
            $display("FAILED time=%0t paddr[%0d] expected %h actual %h", $time, p, ep, paddr[p]);
        end
        if (exception[p] !== ee) begin
            errors++;
            $display("FAILED time=%0t exception[%0d] expected %b actual %b",
                     $time, p, ee, exception[p]);
        end
    endtask

    task automatic start_txn(input logic [1:0] r, input itlb_pkg::vaddr_t va0,
                             input itlb_pkg::vaddr_t va1);
        @(posedge clk);
        #1;
        req      = r;
        vaddr[0] = va0;
        vaddr[1] = va1;
        ready    = 1'b1;
    endtask

    // Checks every cycle that shows a result, until fetch takes it.
    task automatic finish_txn(input int base, output int tags, output logic saw_miss);
        logic        done;
        logic [31:0] rnd;
        done     = 1'b0;
        saw_miss = 1'b0;
        while (!done) begin
            @(negedge clk);
            if (miss) begin
                saw_miss = 1'b1;
            end else begin
                for (int p = 0; p < 2; p++) begin
                    if (req[p]) begin
                        check_port(p);
                    end
                end
                done = ready;
            end
            if (!done) begin
                @(posedge clk);
                #1;
                rnd   = next_rand();
                ready = rnd[31:30] != 2'b00;
            end
        end
        tags = tag_count - base;
    endtask

    task automatic translate(input logic [1:0] r, input itlb_pkg::vaddr_t va0,
                             input itlb_pkg::vaddr_t va1, output int tags,
                             output logic saw_miss);
        int base;
        start_txn(r, va0, va1);
        base = tag_count;
        finish_txn(base, tags, saw_miss);
    endtask

    task automatic do_flush();
        @(posedge clk);
        #1;
        req   = 2'b00;
        flush = 1'b1;
        @(posedge clk);
        #1;
        flush = 1'b0;
    endtask

    function automatic itlb_pkg::vaddr_t good_page();
        itlb_pkg::vaddr_t va;
        pte_t             pte;
        va  = random_vaddr();
        pte = page_model(va[31:12]);
        while (pte.fault) begin
            va  = random_vaddr();
            pte = page_model(va[31:12]);
        end
        return va;
    endfunction

    task automatic expect_tags(input string what, input int got, input int want);
        if (got != want) begin
            errors++;
            $display("%s sent %0d L2 tags where %0d were expected", what, got, want);
        end
    endtask

    task automatic random_test();
        itlb_pkg::vaddr_t va0;
        itlb_pkg::vaddr_t va1;
        logic [31:0]      rnd;
        logic [1:0]       r;
        logic             sm;
        int               tags;
        int               npages;
        int               err0;
        err0 = errors;
        for (int i = 0; i < NUM_RANDOM; i++) begin
            va0 = random_vaddr();
            va1 = random_vaddr();
            rnd = next_rand();
            if (rnd[31:30] == 2'b00) begin
                va1 = {va0[31:12], rnd[11:0]};  // Same page at another offset.
            end
            r = (rnd[29:28] == 2'd0) ? 2'b01 : (rnd[29:28] == 2'd1) ? 2'b10 : 2'b11;
            npages = (r == 2'b11 && va0[31:12] != va1[31:12]) ? 2 : 1;
            translate(r, va0, va1, tags, sm);
            if (tags > npages) begin
                errors++;
                $display("Transaction %0d sent %0d L2 tags for %0d pages", i, tags, npages);
            end
        end
        $display("random translations: %0d transactions, %0d errors", NUM_RANDOM, errors - err0);
    endtask

    task automatic tag_test();
        itlb_pkg::vaddr_t va;
        logic             sm;
        int               tags;
        int               err0;
        err0 = errors;
        do_flush();
        va = random_vaddr();
        translate(2'b11, va, {va[31:12], ~va[11:0]}, tags, sm);
        expect_tags("Same page on both ports", tags, 1);
        do_flush();
        va = random_vaddr();
        translate(2'b11, va, {va[31:22] ^ 10'h001, va[21:0]}, tags, sm);
        expect_tags("Two pages", tags, 2);
        $display("L2 tag count: %0d errors", errors - err0);
    endtask

    task automatic flush_test();
        itlb_pkg::vaddr_t va;
        logic             sm;
        int               tags;
        int               err0;
        err0 = errors;
        va = good_page();
        do_flush();
        translate(2'b01, va, va, tags, sm);
        translate(2'b01, va, va, tags, sm);
        expect_tags("Repeated page", tags, 0);
        do_flush();
        translate(2'b01, va, va, tags, sm);
        expect_tags("Page after flush", tags, 1);
        if (!sm) begin
            errors++;
            $display("miss did not rise for a page translated before the flush");
        end
        $display("flush and retranslate: %0d errors", errors - err0);
    endtask

    // Flush in the middle of a walk and switch to another page.
    task automatic cancel_test();
        itlb_pkg::vaddr_t va_b;
        itlb_pkg::vaddr_t va_c;
        logic             sm;
        int               tags;
        int               base;
        int               err0;
        err0 = errors;
        do_flush();
        va_b = good_page();
        va_c = {va_b[31:22] ^ 10'h002, va_b[21:0]};
        start_txn(2'b01, va_b, va_b);
        base = tag_count;
        while (tag_count == base) begin
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        flush    = 1'b1;
        vaddr[0] = va_c;
        @(posedge clk);
        #1;
        flush = 1'b0;
        base  = tag_count;
        finish_txn(base, tags, sm);
        expect_tags("Walk after cancel", tags, 1);
        $display("flush during walk: %0d errors", errors - err0);
    endtask

    initial begin
        req       = 2'b00;
        vaddr     = '0;
        flush     = 1'b0;
        ready     = 1'b0;
        l2_ready  = 1'b0;
        l2_resp   = '0;
        drv_seed  = 32'h12d3_41c4;
        cyc       = 0;
        checks    = 0;
        errors    = 0;
        tag_count = 0;
        last_idx  = '0;
        @(posedge rst);
        repeat (2) @(posedge clk);
        random_test();
        tag_test();
        flush_test();
        cancel_test();
        repeat (10) @(posedge clk);
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0) begin
            $display("Test passed");
        end else begin
            $display("Test failed");
        end
        $finish;
    end
endmodule

// ==== verilog/itlb_array.sv ====
`timescale 1ns/1ps

module itlb_array #(
    parameter int ENTRIES = 8  // Power of two, at least 4.
) (
    input  logic                   clk,
    input  logic                   rst,
    input  itlb_pkg::vaddr_t [1:0] vaddr,
    input  logic                   flush,
    input  logic                   wr_en,
    input  itlb_pkg::tlb_entry_t   wr_entry,
    output logic [1:0]             hit,
    output itlb_pkg::paddr_t [1:0] lookup_paddr,
    output logic [1:0]             noexec
);
    localparam int IDX_W = $clog2(ENTRIES);

    // Fibonacci feedback taps per LFSR width.
    function automatic logic [7:0] lfsr_taps(input int width);
        case (width)
            2:       return 8'h03;
            3:       return 8'h06;
            4:       return 8'h0c;
            5:       return 8'h14;
            6:       return 8'h30;
            7:       return 8'h60;
            default: return 8'hb8;
        endcase
    endfunction

    localparam logic [7:0] TAPS = lfsr_taps(IDX_W);

    itlb_pkg::tlb_entry_t entries [ENTRIES];
    logic [ENTRIES-1:0]   valid;
    logic [ENTRIES-1:0]   wr_overlap;
    logic [IDX_W-1:0]     wr_idx;
    logic [IDX_W-1:0]     lfsr;
    logic                 lfsr_fb;

    // Zero term lets the sequence pass through every index.
    assign lfsr_fb = (^(lfsr & TAPS[IDX_W-1:0])) ^ ~(|lfsr[IDX_W-2:0]);

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            lfsr <= '0;
        end else begin
            lfsr <= {lfsr[IDX_W-2:0], lfsr_fb};
        end
    end

    // An overlapping entry is replaced in place.
    always_comb begin
        wr_idx = lfsr;
        for (int i = 0; i < ENTRIES; i++) begin
            wr_overlap[i] = valid[i] && entries[i].vpn.vpn1 == wr_entry.vpn.vpn1 &&
                            (entries[i].mega || wr_entry.mega ||
                             entries[i].vpn.vpn0 == wr_entry.vpn.vpn0);
            if (wr_overlap[i]) begin
                wr_idx = IDX_W'(i);
            end
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            valid <= '0;
        end else if (flush) begin
            valid <= '0;
        end else if (wr_en) begin
            valid         <= valid & ~wr_overlap;
            valid[wr_idx] <= wr_entry.valid;
        end
    end

    always_ff @(posedge clk) begin
        if (wr_en) begin
            entries[wr_idx] <= wr_entry;
        end
    end

    for (genvar p = 0; p < 2; p++) begin : g_port
        logic [ENTRIES-1:0]   match;
        itlb_pkg::tlb_entry_t sel;
        itlb_pkg::vpn_t       va_vpn;
        itlb_pkg::ppn_t       ppn;

        assign va_vpn = vaddr[p][itlb_pkg::VADDR_W-1:itlb_pkg::PAGE_OFFSET];

        always_comb begin
            sel = '0;
            for (int i = 0; i < ENTRIES; i++) begin
                match[i] = valid[i] && entries[i].vpn.vpn1 == va_vpn.vpn1 &&
                           (entries[i].mega || entries[i].vpn.vpn0 == va_vpn.vpn0);
                if (match[i]) begin
                    sel = sel | entries[i];
                end
            end
        end

        assign ppn.ppn1        = sel.ppn.ppn1;
        assign ppn.ppn0        = sel.mega ? va_vpn.vpn0 : sel.ppn.ppn0;  // Megapage.
        assign hit[p]          = |match;
        assign noexec[p]       = hit[p] & ~sel.x;
        assign lookup_paddr[p] = {ppn, vaddr[p][itlb_pkg::PAGE_OFFSET-1:0]};

        a_one_hit: assert property (@(posedge clk) disable iff (!rst)
            $onehot0(match));
    end

endmodule

// ==== verilog/itlb_ctrl.sv ====
`timescale 1ns/1ps

module itlb_ctrl (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             req,
    input  itlb_pkg::vaddr_t [1:0] vaddr,
    input  logic                   flush,
    input  logic                   ready,
    input  logic [1:0]             hit,
    input  itlb_pkg::paddr_t [1:0] lookup_paddr,
    input  logic [1:0]             noexec,
    input  logic                   l2_ready,
    input  logic                   resp_hit,
    input  logic                   resp_error,
    input  logic                   resp_fault,
    input  itlb_pkg::paddr_t       new_paddr,
    output itlb_pkg::paddr_t [1:0] paddr,
    output logic [1:0]             exception,
    output logic                   miss,
    output itlb_pkg::l2_req_t      l2_req,
    output itlb_pkg::walk_idx_t    cur_idx
);
    typedef struct packed {
        itlb_pkg::vaddr_t [1:0] vaddr;
        logic [1:0]             miss;
        itlb_pkg::paddr_t [1:0] paddr;
        logic [1:0]             exception;
        itlb_pkg::vaddr_t       req_vaddr;
    } walk_buf_t;

    itlb_pkg::walk_state_t state;
    walk_buf_t             wbuf;
    itlb_pkg::walk_idx_t   idx;
    logic                  req_q;
    logic                  req_d1;
    logic                  req_d2;
    logic                  miss_end;
    logic [1:0]            port_miss;
    logic                  same_page;
    logic                  walking;
    logic                  start;
    logic                  next_addr1;
    logic                  finish;
    logic                  issue;
    logic                  retry;
    itlb_pkg::paddr_t      pair_paddr;

    assign port_miss = req & ~hit;
    assign same_page = vaddr[0][itlb_pkg::VADDR_W-1:itlb_pkg::PAGE_OFFSET] ==
                       vaddr[1][itlb_pkg::VADDR_W-1:itlb_pkg::PAGE_OFFSET];
    assign walking    = state != itlb_pkg::IDLE;
    assign start      = !walking && !miss_end && (|port_miss);
    assign next_addr1 = state == itlb_pkg::WALK_ADDR0 && resp_hit && wbuf.miss[1];
    assign finish     = walking && resp_hit && !next_addr1;
    assign issue      = start | next_addr1;
    // Not taken by L2, or answered with an error.
    assign retry = (req_d2 & ~l2_ready) | resp_error;

    // Port 1 shares the page of port 0 in WALK_ALL.
    assign pair_paddr = {new_paddr[itlb_pkg::PADDR_W-1:itlb_pkg::PAGE_OFFSET],
                         wbuf.vaddr[1][itlb_pkg::PAGE_OFFSET-1:0]};

    assign paddr     = miss_end ? wbuf.paddr : lookup_paddr;
    assign exception = miss_end ? wbuf.exception : (req & hit & noexec & {2{!walking}});
    assign miss      = walking | (~miss_end & (|port_miss));

    assign l2_req.req   = req_q;
    assign l2_req.idx   = idx;
    assign l2_req.vaddr = wbuf.req_vaddr;
    assign cur_idx      = idx;

    always_ff @(posedge clk) begin
        if (start) begin
            wbuf.vaddr     <= vaddr;
            wbuf.miss      <= port_miss;
            wbuf.paddr     <= lookup_paddr;  // Hit port keeps its lookup.
            wbuf.exception <= req & hit & noexec;
            wbuf.req_vaddr <= port_miss[0] ? vaddr[0] : vaddr[1];
        end
        if (next_addr1) begin
            wbuf.req_vaddr <= wbuf.vaddr[1];
        end
        if (resp_hit) begin
            case (state)
                itlb_pkg::WALK_ALL: begin
                    wbuf.paddr[0]     <= new_paddr;
                    wbuf.paddr[1]     <= pair_paddr;
                    wbuf.exception[0] <= resp_fault;
                    wbuf.exception[1] <= resp_fault;
                end
                itlb_pkg::WALK_ADDR0: begin
                    wbuf.paddr[0]     <= new_paddr;
                    wbuf.exception[0] <= resp_fault;
                end
                itlb_pkg::WALK_ADDR1: begin
                    wbuf.paddr[1]     <= new_paddr;
                    wbuf.exception[1] <= resp_fault;
                end
                default: ;
            endcase
        end
    end

    always_ff @(posedge clk or negedge rst) begin
        if (!rst) begin
            state    <= itlb_pkg::IDLE;
            idx      <= '0;
            req_q    <= 1'b0;
            req_d1   <= 1'b0;
            req_d2   <= 1'b0;
            miss_end <= 1'b0;
        end else if (flush) begin
            state    <= itlb_pkg::IDLE;
            idx      <= idx + 1'b1;  // Late answers no longer match.
            req_q    <= 1'b0;
            req_d1   <= 1'b0;
            req_d2   <= 1'b0;
            miss_end <= 1'b0;
        end else begin
            req_q  <= issue | (walking & retry);
            req_d1 <= req_q;
            req_d2 <= req_d1;
            if (issue) begin
                idx <= idx + 1'b1;
            end
            if (miss_end && ready) begin
                miss_end <= 1'b0;
            end
            if (finish) begin
                miss_end <= 1'b1;
            end
            case (state)
                itlb_pkg::IDLE: begin
                    if (start) begin
                        state <= (same_page && (&port_miss)) ? itlb_pkg::WALK_ALL :
                                 port_miss[0] ? itlb_pkg::WALK_ADDR0 : itlb_pkg::WALK_ADDR1;
                    end
                end
                itlb_pkg::WALK_ADDR0: begin
                    if (resp_hit) begin
                        state <= wbuf.miss[1] ? itlb_pkg::WALK_ADDR1 : itlb_pkg::IDLE;
                    end
                end
                default: begin
                    if (resp_hit) begin
                        state <= itlb_pkg::IDLE;
                    end
                end
            endcase
        end
    end

    a_req_pulse: assert property (@(posedge clk) disable iff (!rst)
        l2_req.req |=> !l2_req.req);

    // The walk result shows in the cycle after the last response.
    a_end_no_miss: assert property (@(posedge clk) disable iff (!rst)
        (finish && !flush) |=> !miss);

endmodule

// ==== verilog/itlb_pkg.sv ====
package itlb_pkg;

    localparam int VADDR_W = 32;
    localparam int PADDR_W = 34;
    localparam int PAGE_OFFSET = 12;

    typedef logic [VADDR_W-1:0] vaddr_t;
    typedef logic [PADDR_W-1:0] paddr_t;
    typedef logic [3:0] walk_idx_t;

    // Sv32 virtual page number, two 10-bit levels.
    typedef struct packed {
        logic [9:0] vpn1;
        logic [9:0] vpn0;
    } vpn_t;

    typedef struct packed {
        logic [11:0] ppn1;
        logic [9:0]  ppn0;
    } ppn_t;

    typedef struct packed {
        logic valid;
        vpn_t vpn;
        ppn_t ppn;
        logic mega;  // 4 MiB page, vpn0 ignored.
        logic x;
    } tlb_entry_t;

    typedef struct packed {
        logic      req;  // One-cycle pulse.
        walk_idx_t idx;
        vaddr_t    vaddr;
    } l2_req_t;

    typedef struct packed {
        logic      valid;
        walk_idx_t idx;
        logic      error;  // Request must be sent again.
        logic      fault;
        logic      mega;
        logic      x;
        ppn_t      ppn;
    } l2_resp_t;

    typedef enum logic [1:0] {IDLE, WALK_ADDR0, WALK_ADDR1, WALK_ALL} walk_state_t;

endpackage

// ==== verilog/itlb_refill.sv ====
`timescale 1ns/1ps

module itlb_refill (
    input  itlb_pkg::l2_resp_t   l2_resp,
    input  itlb_pkg::walk_idx_t  cur_idx,
    input  itlb_pkg::vaddr_t     req_vaddr,
    output logic                 resp_hit,
    output logic                 resp_error,
    output logic                 resp_fault,
    output logic                 wr_en,
    output itlb_pkg::tlb_entry_t wr_entry,
    output itlb_pkg::paddr_t     new_paddr
);
    logic           match;
    itlb_pkg::vpn_t req_vpn;
    itlb_pkg::ppn_t ppn;

    // Only the answer to the current request counts.
    assign match      = l2_resp.valid && l2_resp.idx == cur_idx;
    assign resp_hit   = match & ~l2_resp.error;
    assign resp_error = match & l2_resp.error;

    // Fetch sees a page fault for no execute too.
    assign resp_fault = l2_resp.fault | ~l2_resp.x;

    // Faulting pages stay out of the array.
    assign wr_en = resp_hit & ~l2_resp.fault;

    assign req_vpn = req_vaddr[itlb_pkg::VADDR_W-1:itlb_pkg::PAGE_OFFSET];

    assign ppn.ppn1 = l2_resp.ppn.ppn1;
    assign ppn.ppn0 = l2_resp.mega ? req_vpn.vpn0 : l2_resp.ppn.ppn0;

    assign new_paddr = {ppn, req_vaddr[itlb_pkg::PAGE_OFFSET-1:0]};

    assign wr_entry.valid = 1'b1;
    assign wr_entry.vpn   = req_vpn;
    assign wr_entry.ppn   = ppn;
    assign wr_entry.mega  = l2_resp.mega;
    assign wr_entry.x     = l2_resp.x;

endmodule

// ==== verilog/itlb_top.sv ====
`timescale 1ns/1ps

module itlb_top #(
    parameter int ENTRIES = 8
) (
    input  logic                   clk,
    input  logic                   rst,
    input  logic [1:0]             req,
    input  itlb_pkg::vaddr_t [1:0] vaddr,
    input  logic                   flush,
    input  logic                   ready,
    output itlb_pkg::paddr_t [1:0] paddr,
    output logic [1:0]             exception,
    output logic                   miss,
    output itlb_pkg::l2_req_t      l2_req,
    input  logic                   l2_ready,
    input  itlb_pkg::l2_resp_t     l2_resp
);
    logic [1:0]             hit;
    logic [1:0]             noexec;
    itlb_pkg::paddr_t [1:0] lookup_paddr;
    itlb_pkg::walk_idx_t    cur_idx;
    logic                   resp_hit;
    logic                   resp_error;
    logic                   resp_fault;
    logic                   wr_en;
    itlb_pkg::tlb_entry_t   wr_entry;
    itlb_pkg::paddr_t       new_paddr;

    itlb_ctrl i_ctrl (
        .clk          (clk),
        .rst          (rst),
        .req          (req),
        .vaddr        (vaddr),
        .flush        (flush),
        .ready        (ready),
        .hit          (hit),
        .lookup_paddr (lookup_paddr),
        .noexec       (noexec),
        .l2_ready     (l2_ready),
        .resp_hit     (resp_hit),
        .resp_error   (resp_error),
        .resp_fault   (resp_fault),
        .new_paddr    (new_paddr),
        .paddr        (paddr),
        .exception    (exception),
        .miss         (miss),
        .l2_req       (l2_req),
        .cur_idx      (cur_idx)
    );

    itlb_array #(
        .ENTRIES (ENTRIES)
    ) i_array (
        .clk          (clk),
        .rst          (rst),
        .vaddr        (vaddr),
        .flush        (flush),
        .wr_en        (wr_en),
        .wr_entry     (wr_entry),
        .hit          (hit),
        .lookup_paddr (lookup_paddr),
        .noexec       (noexec)
    );

    // Refill works on the address of the request in flight.
    itlb_refill i_refill (
        .l2_resp    (l2_resp),
        .cur_idx    (cur_idx),
        .req_vaddr  (l2_req.vaddr),
        .resp_hit   (resp_hit),
        .resp_error (resp_error),
        .resp_fault (resp_fault),
        .wr_en      (wr_en),
        .wr_entry   (wr_entry),
        .new_paddr  (new_paddr)
    );

endmodule
